// File: fpga_regs_pkg.sv
/*
 * fpga register block shared definitions
 * widths, fixed register values, register map, controller states
 * and the request / gpio write / clock enable bundles
 */
`default_nettype none

package fpga_regs_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int ADDR_W = 7;   // word address into the 128 word aperture
    localparam int DATA_W = 32;
    localparam int BE_W   = 4;   // one strobe per byte lane
    localparam int GPIO_W = 8;

    // ------------------------------------------------------------
    // fixed values
    // ------------------------------------------------------------
    localparam logic [DATA_W-1:0] DEVICE_ID_VAL = {16'h0000, 16'h0000}; // device id 0
    localparam logic [DATA_W-1:0] SCRATCH_RST   = 32'h12345678;
    localparam logic [DATA_W-1:0] DEF_REG_VAL   = 32'hFABDEFAC;         // unmapped marker

    // identity words at the very top of the aperture
    localparam logic [DATA_W-1:0] CUST_PROD_VAL = {16'h0000, 8'h01, 8'h00}; // cust, prod
    localparam logic [DATA_W-1:0] REVISION_VAL  = {16'h0000, 16'h0001};     // major, minor

    // clock control bit positions
    localparam int CLK_EN_4M_BIT = 0;
    localparam int CLK_EN_1M_BIT = 1;

    // ------------------------------------------------------------
    // register map, word addresses
    // ------------------------------------------------------------
    typedef enum logic [ADDR_W-1:0] {
        REG_ID        = 7'h00,
        REG_CLK_CTRL  = 7'h01,
        REG_GPIO_IN   = 7'h02,  // read only
        REG_GPIO_OUT  = 7'h03,
        REG_GPIO_OE   = 7'h04,
        REG_SCRATCH   = 7'h05,
        REG_CUST_PROD = 7'h7E,  // read only
        REG_REVISION  = 7'h7F   // read only
    } reg_addr_e;

    // request / response handshake states
    typedef enum logic [0:0] {
        ST_IDLE = 1'b0,   // ready for a request
        ST_RESP = 1'b1    // response waiting for the host
    } ctrl_state_e;

    // ------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;     // 1 = write
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    // write command into the gpio port
    typedef struct packed {
        logic              out_we;
        logic              oe_we;
        logic [BE_W-1:0]   be;
        logic [DATA_W-1:0] wdata;
    } gpio_wr_t;

    typedef struct packed {
        logic en_4m;
        logic en_1m;
    } clk_en_t;

endpackage

`default_nettype wire

// File: gpio_port.sv
/*
 * gpio port
 * output and output enable registers written from byte lane 0,
 * two flop synchronizer on the input pins
 */
`timescale 1ns/1ps
`default_nettype none

module gpio_port
    import fpga_regs_pkg::*;
(
    input  wire logic              CLK_4M,
    input  wire logic              RST_fb1,

    input  wire gpio_wr_t          gpio_wr_i,   // strobes from the controller
    input  wire logic [GPIO_W-1:0] gpio_i,      // pins, asynchronous
    output logic [GPIO_W-1:0]      gpio_o,
    output logic [GPIO_W-1:0]      gpio_oe_o,
    output logic [GPIO_W-1:0]      gpio_in_o    // synchronized pins
);

    // ------------------------------------------------------------
    // internal signals
    // ------------------------------------------------------------
    logic [GPIO_W-1:0] out_q;
    logic [GPIO_W-1:0] oe_q;
    logic [GPIO_W-1:0] in_meta;   // first sync stage
    logic [GPIO_W-1:0] in_sync;   // second sync stage
    logic              lane0;     // byte 0 strobed

    assign lane0 = gpio_wr_i.be[0];

    // ------------------------------------------------------------
    // output and enable registers
    // ------------------------------------------------------------
    always_ff @(posedge CLK_4M or posedge RST_fb1)
    begin
        if (RST_fb1)
        begin
            out_q <= '0;
            oe_q  <= '0;           // pins start as inputs
        end
        else
        begin
            if (gpio_wr_i.out_we && lane0)
                out_q <= gpio_wr_i.wdata[GPIO_W-1:0];
            if (gpio_wr_i.oe_we && lane0)
                oe_q  <= gpio_wr_i.wdata[GPIO_W-1:0];
        end
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = oe_q;

    // ------------------------------------------------------------
    // input synchronizer
    // ------------------------------------------------------------
    always_ff @(posedge CLK_4M or posedge RST_fb1)
    begin
        if (RST_fb1)
        begin
            in_meta <= '0;
            in_sync <= '0;
        end
        else
        begin
            in_meta <= gpio_i;     // may go metastable
            in_sync <= in_meta;
        end
    end

    assign gpio_in_o = in_sync;    // pins as of 2+ cycles ago

endmodule

`default_nettype wire

// File: clk_out_gate.sv
/*
 * clock output gating
 * divides CLK_4M by four and gates the full and quarter rate clocks
 * glitch free from the synchronized register enables
 */
`timescale 1ns/1ps
`default_nettype none

module clk_out_gate
    import fpga_regs_pkg::*;
(
    input  wire logic    CLK_4M,
    input  wire logic    RST_fb1,

    input  wire clk_en_t clk_en_i,   // from the clock control register
    output logic         clk_4m_o,
    output logic         clk_1m_o
);

    // ------------------------------------------------------------
    // internal signals
    // ------------------------------------------------------------
    logic [1:0] clk_div;     // free running /4
    logic       clk_1m;
    clk_en_t    en_meta;     // sync stage 1
    clk_en_t    en_sync;     // sync stage 2
    logic       on_4m;       // changes on falling edge only
    logic       on_1m;       // changes in divider low phase only

    assign clk_1m = clk_div[1];   // 2 high, 2 low

    always_ff @(posedge CLK_4M or posedge RST_fb1)
    begin
        if (RST_fb1)
            clk_div <= 2'b00;
        else
            clk_div <= clk_div + 2'd1;
    end

    // both enables share one 2 stage synchronizer
    always_ff @(posedge CLK_4M or posedge RST_fb1)
    begin
        if (RST_fb1)
        begin
            en_meta <= '0;
            en_sync <= '0;
        end
        else
        begin
            en_meta <= clk_en_i;
            en_sync <= en_meta;
        end
    end

    // ------------------------------------------------------------
    // enable latches
    // ------------------------------------------------------------
    // CLK_4M is low across the falling edge, so the AND cannot glitch
    always_ff @(negedge CLK_4M or posedge RST_fb1)
    begin
        if (RST_fb1)
            on_4m <= 1'b0;
        else
            on_4m <= en_sync.en_4m;
    end

    // load only when div is 00, the quarter clock is low before and after
    always_ff @(posedge CLK_4M or posedge RST_fb1)
    begin
        if (RST_fb1)
            on_1m <= 1'b0;
        else if (!clk_div[1] && !clk_div[0])
            on_1m <= en_sync.en_1m;
    end

    assign clk_4m_o = CLK_4M & on_4m;
    assign clk_1m_o = clk_1m & on_1m;   // low whenever disabled

endmodule

`default_nettype wire

// File: wb_reg_ctrl.sv
/*
 * register controller
 * single word request/response handshake, address decode, device id,
 * scratch and clock control registers, gpio write strobes, read mux
 */
`timescale 1ns/1ps
`default_nettype none

module wb_reg_ctrl
    import fpga_regs_pkg::*;
(
    input  wire logic              CLK_4M,
    input  wire logic              RST_fb1,

    // request channel
    input  wire logic              req_valid_i,
    input  wire bus_req_t          req_i,
    output logic                   req_ready_o,

    // response channel
    output logic                   rsp_valid_o,
    input  wire logic              rsp_ready_i,
    output logic [DATA_W-1:0]      rsp_rdata_o,

    // gpio port
    output gpio_wr_t               gpio_wr_o,
    input  wire logic [GPIO_W-1:0] gpio_out_i,
    input  wire logic [GPIO_W-1:0] gpio_oe_i,
    input  wire logic [GPIO_W-1:0] gpio_in_i,   // already synchronized

    // clock output gating
    output clk_en_t                clk_en_o
);

    // ------------------------------------------------------------
    // internal signals
    // ------------------------------------------------------------
    ctrl_state_e       state_q;
    ctrl_state_e       state_d;
    reg_addr_e         addr_dec;     // decoded word address
    logic              accept;       // request transfer this edge
    logic              wr_acc;       // accepted write
    logic [DATA_W-1:0] scratch_q;
    clk_en_t           clk_en_q;
    logic [DATA_W-1:0] rdata_mux;

    // merge new data into old data per byte strobe
    function automatic logic [DATA_W-1:0] merge_be(
        input logic [DATA_W-1:0] old_v,
        input logic [DATA_W-1:0] new_v,
        input logic [BE_W-1:0]   be
    );
        logic [DATA_W-1:0] res;
        res = old_v;
        for (int i = 0; i < BE_W; i++)
        begin
            if (be[i])
                res[8*i +: 8] = new_v[8*i +: 8];
        end
        return res;
    endfunction

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------
    assign req_ready_o = (state_q == ST_IDLE);   // one item in flight
    assign rsp_valid_o = (state_q == ST_RESP);
    assign accept      = req_valid_i & req_ready_o;
    assign wr_acc      = accept & req_i.we;
    assign addr_dec    = reg_addr_e'(req_i.addr);

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:
                if (accept)
                    state_d = ST_RESP;      // answer next cycle
            ST_RESP:
                if (rsp_ready_i)
                    state_d = ST_IDLE;      // taken, ready again next cycle
            default:
                state_d = ST_IDLE;
        endcase
    end

    // ------------------------------------------------------------
    // control state and writable registers
    // ------------------------------------------------------------
    always_ff @(posedge CLK_4M or posedge RST_fb1)
    begin
        if (RST_fb1)
        begin
            state_q   <= ST_IDLE;
            scratch_q <= SCRATCH_RST;
            clk_en_q  <= '0;               // both clock outputs off
        end
        else
        begin
            state_q <= state_d;
            if (wr_acc)
            begin
                case (addr_dec)
                    REG_SCRATCH:
                        scratch_q <= merge_be(scratch_q, req_i.wdata, req_i.be);
                    REG_CLK_CTRL:
                        if (req_i.be[0])   // enables live in lane 0
                        begin
                            clk_en_q.en_4m <= req_i.wdata[CLK_EN_4M_BIT];
                            clk_en_q.en_1m <= req_i.wdata[CLK_EN_1M_BIT];
                        end
                    default: ;             // id, identity, gpio in, unmapped
                endcase
            end
        end
    end

    assign clk_en_o = clk_en_q;

    // gpio registers live in the port, strobe them at the accepting edge
    always_comb
    begin
        gpio_wr_o.out_we = wr_acc && (addr_dec == REG_GPIO_OUT);
        gpio_wr_o.oe_we  = wr_acc && (addr_dec == REG_GPIO_OE);
        gpio_wr_o.be     = req_i.be;
        gpio_wr_o.wdata  = req_i.wdata;
    end

    // ------------------------------------------------------------
    // read path
    // ------------------------------------------------------------
    always_comb
    begin
        rdata_mux = '0;
        case (addr_dec)
            REG_ID:        rdata_mux = DEVICE_ID_VAL;
            REG_CLK_CTRL:
            begin
                rdata_mux[CLK_EN_4M_BIT] = clk_en_q.en_4m;   // other bits zero
                rdata_mux[CLK_EN_1M_BIT] = clk_en_q.en_1m;
            end
            REG_GPIO_IN:   rdata_mux = {{(DATA_W-GPIO_W){1'b0}}, gpio_in_i};
            REG_GPIO_OUT:  rdata_mux = {{(DATA_W-GPIO_W){1'b0}}, gpio_out_i};
            REG_GPIO_OE:   rdata_mux = {{(DATA_W-GPIO_W){1'b0}}, gpio_oe_i};
            REG_SCRATCH:   rdata_mux = scratch_q;
            REG_CUST_PROD: rdata_mux = CUST_PROD_VAL;
            REG_REVISION:  rdata_mux = REVISION_VAL;
            default:       rdata_mux = DEF_REG_VAL;   // hole in the map
        endcase
    end

    // captured on accept, so reads see contents before the edge
    // and the value holds while the response waits
    always_ff @(posedge CLK_4M)
    begin
        if (accept)
            rsp_rdata_o <= rdata_mux;
    end

endmodule

`default_nettype wire

// File: fpga_ip_top.sv
/*
 * fpga register and clock output block, top level
 * joins the register controller, gpio port and clock gating
 */
`timescale 1ns/1ps
`default_nettype none

module fpga_ip_top
    import fpga_regs_pkg::*;
(
    input  wire logic              CLK_4M,
    input  wire logic              RST_fb1,

    // host request / response
    input  wire logic              req_valid_i,
    input  wire bus_req_t          req_i,
    output logic                   req_ready_o,
    output logic                   rsp_valid_o,
    input  wire logic              rsp_ready_i,
    output logic [DATA_W-1:0]      rsp_rdata_o,

    // gpio pins, split
    input  wire logic [GPIO_W-1:0] gpio_i,
    output logic [GPIO_W-1:0]      gpio_o,
    output logic [GPIO_W-1:0]      gpio_oe_o,

    // gated clocks
    output logic                   clk_4m_o,
    output logic                   clk_1m_o
);

    // ------------------------------------------------------------
    // internal nets
    // ------------------------------------------------------------
    gpio_wr_t          gpio_wr;     // controller -> gpio port
    logic [GPIO_W-1:0] gpio_in;     // synchronized pins back to the mux
    clk_en_t           clk_en;      // controller -> clock gating

    wb_reg_ctrl u_wb_reg_ctrl (
        .CLK_4M      (CLK_4M),
        .RST_fb1     (RST_fb1),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .gpio_wr_o   (gpio_wr),
        .gpio_out_i  (gpio_o),      // readback of the pin drivers
        .gpio_oe_i   (gpio_oe_o),
        .gpio_in_i   (gpio_in),
        .clk_en_o    (clk_en)
    );

    gpio_port u_gpio_port (
        .CLK_4M    (CLK_4M),
        .RST_fb1   (RST_fb1),
        .gpio_wr_i (gpio_wr),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o),
        .gpio_in_o (gpio_in)
    );

    clk_out_gate u_clk_out_gate (
        .CLK_4M   (CLK_4M),
        .RST_fb1  (RST_fb1),
        .clk_en_i (clk_en),
        .clk_4m_o (clk_4m_o),
        .clk_1m_o (clk_1m_o)
    );

endmodule

`default_nettype wire

// File: fpga_ip_chk.sv
/*
 * handshake assertions for the register controller
 * bound into every wb_reg_ctrl instance
 */
`timescale 1ns/1ps
`default_nettype none

module fpga_ip_chk
    import fpga_regs_pkg::*;
(
    input wire logic              CLK_4M,
    input wire logic              RST_fb1,
    input wire logic              req_valid_i,
    input wire logic              req_ready_i,
    input wire logic              rsp_valid_i,
    input wire logic              rsp_ready_i,
    input wire logic [DATA_W-1:0] rsp_rdata_i
);

    // ------------------------------------------------------------
    // one item in flight
    // ------------------------------------------------------------
    // ready held low until the response is taken
    a_ready_low: assert property (@(posedge CLK_4M) disable iff (RST_fb1)
        rsp_valid_i |-> !req_ready_i ##1 (req_ready_i == $past(rsp_ready_i)))
        else $error("request ready not low while a response waits or not back after it");

    // a waiting response keeps its data
    a_data_held: assert property (@(posedge CLK_4M) disable iff (RST_fb1)
        (rsp_valid_i && !rsp_ready_i) |=> (rsp_valid_i && $stable(rsp_rdata_i)))
        else $error("response dropped or changed before it was taken");

    // accept to response is exactly one cycle
    a_latency: assert property (@(posedge CLK_4M) disable iff (RST_fb1)
        (req_valid_i && req_ready_i) |=> $rose(rsp_valid_i))
        else $error("response not raised one cycle after acceptance");

endmodule

bind wb_reg_ctrl fpga_ip_chk u_fpga_ip_chk (
    .CLK_4M      (CLK_4M),
    .RST_fb1     (RST_fb1),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_i (rsp_rdata_o)
);

`default_nettype wire

// File: tb_fpga_ip_top.sv
/*
 * testbench for the fpga register and clock output block
 * random register traffic checked against a reference model,
 * handshake stalls and gated clock output checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_ip_top
    import fpga_regs_pkg::*;
();

    localparam int TIMEOUT = 50;   // cycles allowed per handshake wait

    logic              CLK_4M;
    logic              RST_fb1;
    logic              req_valid_i;
    bus_req_t          req_i;
    logic              req_ready_o;
    logic              rsp_valid_o;
    logic              rsp_ready_i;
    logic [DATA_W-1:0] rsp_rdata_o;
    logic [GPIO_W-1:0] gpio_i;
    logic [GPIO_W-1:0] gpio_o;
    logic [GPIO_W-1:0] gpio_oe_o;
    logic              clk_4m_o;
    logic              clk_1m_o;

    integer            seed;
    int                errors;
    int                err_mark;      // error count at test start
    int                tests_run;
    int                tests_failed;
    int                stall_cycles;  // total host stall cycles seen
    int                waited;
    int                edges;
    logic              prev;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] scratch_m;     // reference model state
    logic [1:0]        clk_ctrl_m;    // bit 1 en_1m, bit 0 en_4m
    logic [GPIO_W-1:0] gpio_out_m;
    logic [GPIO_W-1:0] gpio_oe_m;

    fpga_ip_top u_fpga_ip_top (.*);

    always #20 CLK_4M = ~CLK_4M;    // 40 ns period

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    function automatic logic [DATA_W-1:0] lane_mask(input logic [BE_W-1:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] a);
        case (a)
            REG_ID:        return DEVICE_ID_VAL;
            REG_CLK_CTRL:  return {30'd0, clk_ctrl_m};
            REG_GPIO_IN:   return {24'd0, gpio_i};    // pins held long enough
            REG_GPIO_OUT:  return {24'd0, gpio_out_m};
            REG_GPIO_OE:   return {24'd0, gpio_oe_m};
            REG_SCRATCH:   return scratch_m;
            REG_CUST_PROD: return CUST_PROD_VAL;
            REG_REVISION:  return REVISION_VAL;
            default:       return DEF_REG_VAL;
        endcase
    endfunction

    task automatic model_write(input logic [ADDR_W-1:0] a, input logic [BE_W-1:0] be,
                               input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] m;
        m = lane_mask(be);
        case (a)
            REG_SCRATCH:  scratch_m = (scratch_m & ~m) | (d & m);
            REG_CLK_CTRL: if (be[0]) clk_ctrl_m = d[1:0];   // lane 0 only
            REG_GPIO_OUT: if (be[0]) gpio_out_m = d[GPIO_W-1:0];
            REG_GPIO_OE:  if (be[0]) gpio_oe_m = d[GPIO_W-1:0];
            default: ;                                      // read only or hole
        endcase
    endtask

    // ------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------
    task automatic report_mismatch(input string sig, input logic [DATA_W-1:0] got,
                                   input logic [DATA_W-1:0] exp);
        errors++;
        $display("FAIL t=%0t %s got %h expected %h", $time, sig, got, exp);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic close_run();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        report_problem({"timed out, ", what});
        close_run();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ------------------------------------------------------------
    // host side of the bus, entered and left on a falling edge
    // ------------------------------------------------------------
    task automatic bus_access(input logic [ADDR_W-1:0] a, input logic we,
                              input logic [BE_W-1:0] be, input logic [DATA_W-1:0] d,
                              output logic [DATA_W-1:0] rdata);
        int                wait_n;
        int                stall;
        logic [DATA_W-1:0] held;
        req_i       = '{addr: a, we: we, be: be, wdata: d};
        req_valid_i = 1'b1;
        wait_n      = 0;
        while (!req_ready_o && wait_n < TIMEOUT)
        begin
            @(negedge CLK_4M);
            wait_n++;
        end
        if (!req_ready_o)
            abort_on_timeout("request never accepted");
        @(negedge CLK_4M);                     // accepting edge is behind us
        req_valid_i = 1'b0;
        if (we)
            model_write(a, be, d);
        wait_n = 0;
        while (!rsp_valid_o && wait_n < TIMEOUT)
        begin
            @(negedge CLK_4M);
            wait_n++;
        end
        if (!rsp_valid_o)
            abort_on_timeout("no response after an accepted request");
        if (wait_n != 0)
            report_problem("response did not follow acceptance by one cycle");
        held  = rsp_rdata_o;
        stall = $random(seed) & 3;             // 0 to 3 cycles of back-pressure
        repeat (stall)
        begin
            @(negedge CLK_4M);
            stall_cycles++;
            if (rsp_valid_o !== 1'b1) report_mismatch("rsp_valid_o", rsp_valid_o, 1'b1);
            if (rsp_rdata_o !== held) report_mismatch("rsp_rdata_o", rsp_rdata_o, held);
            if (req_ready_o !== 1'b0) report_mismatch("req_ready_o", req_ready_o, 1'b0);
        end
        rsp_ready_i = 1'b1;
        @(negedge CLK_4M);
        rsp_ready_i = 1'b0;
        if (req_ready_o !== 1'b1) report_mismatch("req_ready_o", req_ready_o, 1'b1);
        rdata = held;
    endtask

    task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [BE_W-1:0] be,
                             input logic [DATA_W-1:0] d);
        logic [DATA_W-1:0] discard;
        bus_access(a, 1'b1, be, d, discard);
    endtask

    task automatic read_check(input logic [ADDR_W-1:0] a);
        logic [DATA_W-1:0] exp;
        logic [DATA_W-1:0] got;
        exp = model_read(a);   // contents before the accepting edge
        bus_access(a, 1'b0, 4'hF, 32'h0, got);
        if (got !== exp) report_mismatch($sformatf("rsp_rdata_o[%02h]", a), got, exp);
    endtask

    task automatic reread_all();
        for (int a = 0; a <= REG_SCRATCH; a++)
            read_check(a);
        read_check(REG_CUST_PROD);
        read_check(REG_REVISION);
    endtask

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial
    begin
        seed = 32'hd8f173ed;
        {errors, err_mark, tests_run, tests_failed, stall_cycles} = '0;
        CLK_4M      = 1'b0;
        RST_fb1     = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b0;
        gpio_i      = '0;
        scratch_m   = SCRATCH_RST;
        clk_ctrl_m  = '0;
        gpio_out_m  = '0;
        gpio_oe_m   = '0;
        repeat (5) @(negedge CLK_4M);
        RST_fb1 = 1'b0;

        // 1: reset state
        if (req_ready_o !== 1'b1) report_mismatch("req_ready_o", req_ready_o, 1'b1);
        if (rsp_valid_o !== 1'b0) report_mismatch("rsp_valid_o", rsp_valid_o, 1'b0);
        if (gpio_o !== 8'h00) report_mismatch("gpio_o", gpio_o, 8'h00);
        if (gpio_oe_o !== 8'h00) report_mismatch("gpio_oe_o", gpio_oe_o, 8'h00);
        @(posedge CLK_4M);
        #10;                                   // middle of the high phase
        if (clk_4m_o !== 1'b0) report_mismatch("clk_4m_o", clk_4m_o, 1'b0);
        if (clk_1m_o !== 1'b0) report_mismatch("clk_1m_o", clk_1m_o, 1'b0);
        @(negedge CLK_4M);
        reread_all();
        end_test("reset values");

        // 2: scratch byte lanes
        repeat (16)
        begin
            write_reg(REG_SCRATCH, $random(seed), $random(seed));
            read_check(REG_SCRATCH);
        end
        end_test("scratch byte enables");

        // 3: gpio out, enable and input path
        repeat (6)
        begin
            write_reg(REG_GPIO_OUT, $random(seed), $random(seed));
            if (gpio_o !== gpio_out_m) report_mismatch("gpio_o", gpio_o, gpio_out_m);
            write_reg(REG_GPIO_OE, $random(seed), $random(seed));
            if (gpio_oe_o !== gpio_oe_m) report_mismatch("gpio_oe_o", gpio_oe_o, gpio_oe_m);
            gpio_i = $random(seed);
            repeat (3) @(negedge CLK_4M);      // through the synchronizer
            read_check(REG_GPIO_IN);
        end
        read_check(REG_GPIO_OUT);
        read_check(REG_GPIO_OE);
        end_test("gpio registers");

        // 4: holes in the map, 0x06 to 0x7d
        repeat (10)
        begin
            addr = 7'h06 + ($unsigned($random(seed)) % 120);
            read_check(addr);
            write_reg(addr, 4'hF, $random(seed));
            reread_all();
        end
        end_test("unmapped addresses");

        // 5: back-pressure, checked inside every access
        waited = stall_cycles;
        repeat (12)
        begin
            write_reg(REG_SCRATCH, 4'hF, $random(seed));
            read_check(REG_SCRATCH);
        end
        if (stall_cycles == waited)
            report_problem("no response was ever stalled by the host");
        end_test("response stalls");

        // 6: gated clock outputs, quarter rate first
        write_reg(REG_CLK_CTRL, 4'h1, 32'h2);
        waited = 0;
        while (clk_1m_o !== 1'b1 && waited < 8)
        begin
            @(negedge CLK_4M);
            waited++;
        end
        if (clk_1m_o !== 1'b1) report_problem("clk_1m_o did not start within 8 cycles");
        edges = 0;
        prev  = clk_1m_o;
        repeat (40)
        begin
            @(negedge CLK_4M);
            if (clk_1m_o && !prev)
                edges++;
            prev = clk_1m_o;
        end
        if (edges != 10) report_mismatch("clk_1m_o rising edges", edges, 10);
        write_reg(REG_CLK_CTRL, 4'h1, 32'h3);
        read_check(REG_CLK_CTRL);
        waited = 0;
        do
        begin
            @(posedge CLK_4M);
            #10;
            waited++;
        end
        while (clk_4m_o !== 1'b1 && waited < 8);
        if (clk_4m_o !== 1'b1) report_problem("clk_4m_o did not start within 8 cycles");
        repeat (8)
        begin
            @(negedge CLK_4M);
            #10;
            if (clk_4m_o !== 1'b0) report_mismatch("clk_4m_o", clk_4m_o, 1'b0);
            @(posedge CLK_4M);
            #10;
            if (clk_4m_o !== 1'b1) report_mismatch("clk_4m_o", clk_4m_o, 1'b1);
        end
        @(negedge CLK_4M);
        write_reg(REG_CLK_CTRL, 4'h1, 32'h0);
        repeat (8) @(negedge CLK_4M);
        repeat (20)
        begin
            @(posedge CLK_4M);
            #10;                               // both clocks would be high here
            if (clk_4m_o !== 1'b0) report_mismatch("clk_4m_o", clk_4m_o, 1'b0);
            if (clk_1m_o !== 1'b0) report_mismatch("clk_1m_o", clk_1m_o, 1'b0);
        end
        @(negedge CLK_4M);
        read_check(REG_CLK_CTRL);
        end_test("clock outputs");

        close_run();
    end

endmodule

`default_nettype wire

// File: flist.f
fpga_regs_pkg.sv
gpio_port.sv
clk_out_gate.sv
wb_reg_ctrl.sv
fpga_ip_top.sv
fpga_ip_chk.sv
tb_fpga_ip_top.sv
